//--- common/regbus_defines.svh
////////////////////////////////////////
// Build-time parameters of the AXI4-Lite
// register slave. Include wherever a width,
// the register count, the base address or
// the buffer option is needed.
////////////////////////////////////////
`ifndef REGBUS_DEFINES_SVH
`define REGBUS_DEFINES_SVH

// Register and AXI data width, strobe is this over 8
`define REGBUS_DATA_WIDTH 32

// Power of two, at most 256
`define REGBUS_NUM_REGISTERS 16

// Wide enough for the largest register count
`define REGBUS_INDEX_WIDTH 8

`define REGBUS_BASE_ADDRESS 32'h4000_0000

// 1 adds an output register to every skid buffer
`define REGBUS_REGISTERED_BUFFERS 0

`endif

//--- common/regbus_pkg.sv
////////////////////////////////////////
// Types shared by the register slave and
// its testbench: AXI4-Lite channel
// payloads and the internal register
// request and response strobes.
////////////////////////////////////////
`include "regbus_defines.svh"

package regbus_pkg;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // AXI4-Lite channel payloads, valid and ready travel separately
    typedef struct packed {
        logic [31:0] addr;
    } axil_aw_t;

    typedef struct packed {
        logic [`REGBUS_DATA_WIDTH-1:0]   data;
        logic [`REGBUS_DATA_WIDTH/8-1:0] strb;
    } axil_w_t;

    typedef struct packed {
        logic [31:0] addr;
    } axil_ar_t;

    typedef struct packed {
        logic [1:0] resp;
    } axil_b_t;

    typedef struct packed {
        logic [`REGBUS_DATA_WIDTH-1:0] data;
        logic [1:0]                    resp;
    } axil_r_t;

    // Single-cycle strobes between control unit and register bank
    typedef struct packed {
        logic                            valid;
        logic [`REGBUS_INDEX_WIDTH-1:0]  index;
        logic [`REGBUS_DATA_WIDTH-1:0]   data;
        logic [`REGBUS_DATA_WIDTH/8-1:0] strb;
    } reg_write_t;

    typedef struct packed {
        logic                           valid;
        logic [`REGBUS_INDEX_WIDTH-1:0] index;
    } reg_read_req_t;

    typedef struct packed {
        logic                          valid;
        logic [`REGBUS_DATA_WIDTH-1:0] data;
    } reg_read_rsp_t;

endpackage

//--- axil_slave/axil_skid_buffer.sv
////////////////////////////////////////
// Valid/ready skid buffer for one AXI
// channel. in_ready comes from a flop, so
// it never depends on out_ready. Set
// REGISTER_OUTPUT to add one output stage.
////////////////////////////////////////
module axil_skid_buffer #(
    parameter int DATA_WIDTH      = 32,
    parameter bit REGISTER_OUTPUT = 1'b0
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic [DATA_WIDTH-1:0] in_data,
    output logic                  out_valid,
    input  logic                  out_ready,
    output logic [DATA_WIDTH-1:0] out_data
);

    // Skid entry holds one item that could not move on
    logic                  skid_valid;
    logic [DATA_WIDTH-1:0] skid_data;

    // Stage feeding the output, either directly or through a register
    logic                  stage_valid;
    logic                  stage_ready;
    logic [DATA_WIDTH-1:0] stage_data;

    assign in_ready    = ~skid_valid;
    assign stage_valid = in_valid | skid_valid;
    assign stage_data  = skid_valid ? skid_data : in_data;

    always_ff @(posedge clock) begin
        if (!reset) begin
            skid_valid <= 1'b0;
        end else if (in_valid && in_ready && !stage_ready) begin
            skid_valid <= 1'b1;
        end else if (stage_ready) begin
            skid_valid <= 1'b0;
        end
    end

    // Capture whenever empty, only kept when the output stalls
    always_ff @(posedge clock) begin
        if (in_ready) begin
            skid_data <= in_data;
        end
    end

    generate
        if (REGISTER_OUTPUT) begin : g_output_register
            assign stage_ready = ~out_valid | out_ready;

            always_ff @(posedge clock) begin
                if (!reset) begin
                    out_valid <= 1'b0;
                end else if (stage_ready) begin
                    out_valid <= stage_valid;
                end
            end

            always_ff @(posedge clock) begin
                if (stage_ready) begin
                    out_data <= stage_data;
                end
            end
        end else begin : g_pass_through
            // Empty buffer hands the input on in the same cycle
            assign stage_ready = out_ready;
            assign out_valid   = stage_valid;
            assign out_data    = stage_data;
        end
    endgenerate

endmodule

//--- axil_slave/axil_register_cu.sv
////////////////////////////////////////
// AXI4-Lite control unit. Buffers AW, W
// and AR, pairs each write address with
// its data, turns addresses into register
// indices and drives the B and R channels.
// Talks to the bank with one-cycle strobes.
////////////////////////////////////////
`include "regbus_defines.svh"

module axil_register_cu (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      aw_valid,
    output logic                      aw_ready,
    input  regbus_pkg::axil_aw_t      aw,
    input  logic                      w_valid,
    output logic                      w_ready,
    input  regbus_pkg::axil_w_t       w,
    output logic                      b_valid,
    input  logic                      b_ready,
    output regbus_pkg::axil_b_t       b,
    input  logic                      ar_valid,
    output logic                      ar_ready,
    input  regbus_pkg::axil_ar_t      ar,
    output logic                      r_valid,
    input  logic                      r_ready,
    output regbus_pkg::axil_r_t       r,
    output regbus_pkg::reg_write_t    reg_write,
    output regbus_pkg::reg_read_req_t reg_read_req,
    input  regbus_pkg::reg_read_rsp_t reg_read_rsp
);

    regbus_pkg::axil_aw_t aw_buf;
    regbus_pkg::axil_w_t  w_buf;
    regbus_pkg::axil_ar_t ar_buf;
    logic                 aw_buf_valid;
    logic                 w_buf_valid;
    logic                 ar_buf_valid;

    logic                 write_fire;
    logic                 read_fire;
    logic [29:0]          write_word;
    logic [29:0]          read_word;
    logic                 write_in_range;
    logic                 read_in_range;

    // One read in flight, with its range check kept for the reply
    logic                          read_pending;
    logic                          read_pending_in_range;
    logic [`REGBUS_DATA_WIDTH-1:0] r_data;

    // Word offset from the base, low two address bits dropped
    function automatic logic [29:0] address_to_word(input logic [31:0] address);
        logic [31:0] offset;
        offset = address - `REGBUS_BASE_ADDRESS;
        return offset[31:2];
    endfunction

    axil_skid_buffer #(
        .DATA_WIDTH($bits(regbus_pkg::axil_aw_t)),
        .REGISTER_OUTPUT(`REGBUS_REGISTERED_BUFFERS)
    ) aw_buffer_inst (
        .clock(clock),
        .reset(reset),
        .in_valid(aw_valid),
        .in_ready(aw_ready),
        .in_data(aw),
        .out_valid(aw_buf_valid),
        .out_ready(write_fire),
        .out_data(aw_buf)
    );

    axil_skid_buffer #(
        .DATA_WIDTH($bits(regbus_pkg::axil_w_t)),
        .REGISTER_OUTPUT(`REGBUS_REGISTERED_BUFFERS)
    ) w_buffer_inst (
        .clock(clock),
        .reset(reset),
        .in_valid(w_valid),
        .in_ready(w_ready),
        .in_data(w),
        .out_valid(w_buf_valid),
        .out_ready(write_fire),
        .out_data(w_buf)
    );

    axil_skid_buffer #(
        .DATA_WIDTH($bits(regbus_pkg::axil_ar_t)),
        .REGISTER_OUTPUT(`REGBUS_REGISTERED_BUFFERS)
    ) ar_buffer_inst (
        .clock(clock),
        .reset(reset),
        .in_valid(ar_valid),
        .in_ready(ar_ready),
        .in_data(ar),
        .out_valid(ar_buf_valid),
        .out_ready(read_fire),
        .out_data(ar_buf)
    );

    // Write needs both halves and room in the B slot
    assign write_fire     = aw_buf_valid & w_buf_valid & (~b_valid | b_ready);
    assign write_word     = address_to_word(aw_buf.addr);
    assign write_in_range = write_word < 30'(`REGBUS_NUM_REGISTERS);

    // Out-of-range writes are still acknowledged on B
    assign reg_write = '{
        valid: write_fire & write_in_range,
        index: write_word[`REGBUS_INDEX_WIDTH-1:0],
        data:  w_buf.data,
        strb:  w_buf.strb
    };

    assign b = '{resp: regbus_pkg::RESP_OKAY};

    always_ff @(posedge clock) begin
        if (!reset) begin
            b_valid <= 1'b0;
        end else if (write_fire) begin
            b_valid <= 1'b1;
        end else if (b_ready) begin
            b_valid <= 1'b0;
        end
    end

    // R slot is free or being emptied when a read is issued
    assign read_fire     = ar_buf_valid & ~read_pending & (~r_valid | r_ready);
    assign read_word     = address_to_word(ar_buf.addr);
    assign read_in_range = read_word < 30'(`REGBUS_NUM_REGISTERS);

    assign reg_read_req = '{
        valid: read_fire,
        index: read_word[`REGBUS_INDEX_WIDTH-1:0]
    };

    always_ff @(posedge clock) begin
        if (!reset) begin
            read_pending <= 1'b0;
            r_valid      <= 1'b0;
        end else begin
            if (read_fire) begin
                read_pending <= 1'b1;
            end else if (reg_read_rsp.valid) begin
                read_pending <= 1'b0;
            end
            if (reg_read_rsp.valid) begin
                r_valid <= 1'b1;
            end else if (r_ready) begin
                r_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (read_fire) begin
            read_pending_in_range <= read_in_range;
        end
        // Large offsets alias in the index, so they are zeroed here
        if (reg_read_rsp.valid) begin
            r_data <= read_pending_in_range ? reg_read_rsp.data : '0;
        end
    end

    assign r = '{data: r_data, resp: regbus_pkg::RESP_OKAY};

endmodule

//--- rtl/register_bank.sv
////////////////////////////////////////
// Register bank behind the control unit.
// Applies byte-strobed writes, answers
// each read one cycle later and drives
// all register values out in parallel.
////////////////////////////////////////
`include "regbus_defines.svh"

module register_bank (
    input  logic                      clock,
    input  logic                      reset,
    input  regbus_pkg::reg_write_t    reg_write,
    input  regbus_pkg::reg_read_req_t reg_read_req,
    output regbus_pkg::reg_read_rsp_t reg_read_rsp,
    output logic [`REGBUS_NUM_REGISTERS-1:0][`REGBUS_DATA_WIDTH-1:0] registers
);

    localparam int INDEX_BITS = $clog2(`REGBUS_NUM_REGISTERS);
    localparam int STRB_WIDTH = `REGBUS_DATA_WIDTH / 8;

    logic                          write_hit;
    logic                          read_hit;
    logic [INDEX_BITS-1:0]         write_slot;
    logic [INDEX_BITS-1:0]         read_slot;
    logic                          rsp_valid;
    logic [`REGBUS_DATA_WIDTH-1:0] rsp_data;

    // Byte k of the result comes from new_data when strobe bit k is set
    function automatic logic [`REGBUS_DATA_WIDTH-1:0] merge_bytes(
        input logic [`REGBUS_DATA_WIDTH-1:0] old_data,
        input logic [`REGBUS_DATA_WIDTH-1:0] new_data,
        input logic [STRB_WIDTH-1:0]         strobe
    );
        logic [`REGBUS_DATA_WIDTH-1:0] merged;
        merged = old_data;
        for (int k = 0; k < STRB_WIDTH; k++) begin
            if (strobe[k]) begin
                merged[k*8 +: 8] = new_data[k*8 +: 8];
            end
        end
        return merged;
    endfunction

    // One spare bit so a full 256-entry bank compares correctly
    assign write_hit = {1'b0, reg_write.index} < (`REGBUS_INDEX_WIDTH+1)'(`REGBUS_NUM_REGISTERS);
    assign read_hit  = {1'b0, reg_read_req.index} <
                       (`REGBUS_INDEX_WIDTH+1)'(`REGBUS_NUM_REGISTERS);

    assign write_slot = reg_write.index[INDEX_BITS-1:0];
    assign read_slot  = reg_read_req.index[INDEX_BITS-1:0];

    always_ff @(posedge clock) begin
        if (!reset) begin
            registers <= '0;
        end else if (reg_write.valid && write_hit) begin
            registers[write_slot] <= merge_bytes(registers[write_slot],
                                                 reg_write.data, reg_write.strb);
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= reg_read_req.valid;
        end
    end

    // Unmapped indices read as zero
    always_ff @(posedge clock) begin
        if (reg_read_req.valid) begin
            rsp_data <= read_hit ? registers[read_slot] : '0;
        end
    end

    assign reg_read_rsp = '{valid: rsp_valid, data: rsp_data};

endmodule

//--- rtl/axil_register_subsystem.sv
////////////////////////////////////////
// Top of the AXI4-Lite register slave.
// Connects the control unit to the bank
// and brings every register out to the
// user logic.
////////////////////////////////////////
`include "regbus_defines.svh"

module axil_register_subsystem (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 aw_valid,
    output logic                 aw_ready,
    input  regbus_pkg::axil_aw_t aw,
    input  logic                 w_valid,
    output logic                 w_ready,
    input  regbus_pkg::axil_w_t  w,
    output logic                 b_valid,
    input  logic                 b_ready,
    output regbus_pkg::axil_b_t  b,
    input  logic                 ar_valid,
    output logic                 ar_ready,
    input  regbus_pkg::axil_ar_t ar,
    output logic                 r_valid,
    input  logic                 r_ready,
    output regbus_pkg::axil_r_t  r,
    output logic [`REGBUS_NUM_REGISTERS-1:0][`REGBUS_DATA_WIDTH-1:0] registers
);

    regbus_pkg::reg_write_t    reg_write;
    regbus_pkg::reg_read_req_t reg_read_req;
    regbus_pkg::reg_read_rsp_t reg_read_rsp;

    axil_register_cu axil_register_cu_inst (
        .clock(clock),
        .reset(reset),
        .aw_valid(aw_valid),
        .aw_ready(aw_ready),
        .aw(aw),
        .w_valid(w_valid),
        .w_ready(w_ready),
        .w(w),
        .b_valid(b_valid),
        .b_ready(b_ready),
        .b(b),
        .ar_valid(ar_valid),
        .ar_ready(ar_ready),
        .ar(ar),
        .r_valid(r_valid),
        .r_ready(r_ready),
        .r(r),
        .reg_write(reg_write),
        .reg_read_req(reg_read_req),
        .reg_read_rsp(reg_read_rsp)
    );

    register_bank register_bank_inst (
        .clock(clock),
        .reset(reset),
        .reg_write(reg_write),
        .reg_read_req(reg_read_req),
        .reg_read_rsp(reg_read_rsp),
        .registers(registers)
    );

endmodule

//--- sim/tb_axil_register_subsystem.sv
////////////////////////////////////////
// Directed testbench for the AXI4-Lite
// register slave. Acts as the AXI master,
// keeps a model of the register bank and
// checks every response against it.
////////////////////////////////////////
`include "regbus_defines.svh"

module tb_axil_register_subsystem;

    localparam int NUM_REGS = `REGBUS_NUM_REGISTERS;
    // Reads and writes issued by all tests together
    localparam int TRANSACTIONS = 170;

    logic                 clock;
    logic                 reset;
    logic                 aw_valid;
    logic                 aw_ready;
    regbus_pkg::axil_aw_t aw;
    logic                 w_valid;
    logic                 w_ready;
    regbus_pkg::axil_w_t  w;
    logic                 b_valid;
    logic                 b_ready;
    regbus_pkg::axil_b_t  b;
    logic                 ar_valid;
    logic                 ar_ready;
    regbus_pkg::axil_ar_t ar;
    logic                 r_valid;
    logic                 r_ready;
    regbus_pkg::axil_r_t  r;
    logic [`REGBUS_NUM_REGISTERS-1:0][`REGBUS_DATA_WIDTH-1:0] registers;

    logic [31:0] model [NUM_REGS];

    axil_register_subsystem axil_register_subsystem_inst (
        .clock(clock),
        .reset(reset),
        .aw_valid(aw_valid),
        .aw_ready(aw_ready),
        .aw(aw),
        .w_valid(w_valid),
        .w_ready(w_ready),
        .w(w),
        .b_valid(b_valid),
        .b_ready(b_ready),
        .b(b),
        .ar_valid(ar_valid),
        .ar_ready(ar_ready),
        .ar(ar),
        .r_valid(r_valid),
        .r_ready(r_ready),
        .r(r),
        .registers(registers)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    function automatic logic [31:0] reg_address(input int index, input int offset);
        return `REGBUS_BASE_ADDRESS + 32'(index * 4 + offset);
    endfunction

    // A set strobe bit takes the whole new byte
    function automatic logic [31:0] apply_strobe(input logic [31:0] old_value,
            input logic [31:0] new_value, input logic [3:0] strobe);
        logic [31:0] mask;
        mask = {{8{strobe[3]}}, {8{strobe[2]}}, {8{strobe[1]}}, {8{strobe[0]}}};
        return (old_value & ~mask) | (new_value & mask);
    endfunction

    task automatic check_value(input string test_name, input logic [31:0] expected,
            input logic [31:0] actual);
        if (expected !== actual) begin
            $display("** Error: %s expected %h, actual %h", test_name, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "%s stopped on a wrong value", test_name);
        end
    endtask

    task automatic compare_registers(input string test_name);
        for (int i = 0; i < NUM_REGS; i++) begin
            check_value(test_name, model[i], registers[i]);
        end
    endtask

    // Channel drivers start on a falling edge
    task automatic send_aw(input logic [31:0] address, input int delay);
        repeat (delay) @(negedge clock);
        aw_valid = 1'b1;
        aw = '{addr: address};
        while (!aw_ready) @(negedge clock);
        @(negedge clock);
        aw_valid = 1'b0;
    endtask

    task automatic send_w(input logic [31:0] data, input logic [3:0] strobe, input int delay);
        repeat (delay) @(negedge clock);
        w_valid = 1'b1;
        w = '{data: data, strb: strobe};
        while (!w_ready) @(negedge clock);
        @(negedge clock);
        w_valid = 1'b0;
    endtask

    // Hold is the number of cycles b_ready stays low after b_valid
    task automatic axi_write(input string test_name, input logic [31:0] address,
            input logic [31:0] data, input logic [3:0] strobe,
            input int aw_delay, input int w_delay, input int hold);
        logic [31:0] word;
        word = (address - `REGBUS_BASE_ADDRESS) >> 2;
        @(negedge clock);
        fork
            send_aw(address, aw_delay);
            send_w(data, strobe, w_delay);
        join
        while (!b_valid) @(negedge clock);
        repeat (hold) @(negedge clock);
        // The response must survive the stall
        check_value(test_name, 32'd1, 32'(b_valid));
        check_value(test_name, 32'(regbus_pkg::RESP_OKAY), 32'(b.resp));
        b_ready = 1'b1;
        @(negedge clock);
        b_ready = 1'b0;
        // A second response here would be a duplicate
        check_value(test_name, 32'd0, 32'(b_valid));
        if (word < NUM_REGS) begin
            model[word] = apply_strobe(model[word], data, strobe);
        end
    endtask

    task automatic axi_read(input string test_name, input logic [31:0] address,
            input logic [31:0] expected, input int hold);
        @(negedge clock);
        ar_valid = 1'b1;
        ar = '{addr: address};
        while (!ar_ready) @(negedge clock);
        @(negedge clock);
        ar_valid = 1'b0;
        while (!r_valid) @(negedge clock);
        repeat (hold) @(negedge clock);
        check_value(test_name, 32'd1, 32'(r_valid));
        check_value(test_name, expected, r.data);
        check_value(test_name, 32'(regbus_pkg::RESP_OKAY), 32'(r.resp));
        r_ready = 1'b1;
        @(negedge clock);
        r_ready = 1'b0;
        check_value(test_name, 32'd0, 32'(r_valid));
    endtask

    task automatic test_reset_state();
        check_value("reset_state", 32'd0, 32'(b_valid));
        check_value("reset_state", 32'd0, 32'(r_valid));
        for (int i = 0; i < NUM_REGS; i++) begin
            axi_read("reset_state", reg_address(i, 0), 32'd0, 0);
        end
        compare_registers("reset_state");
    endtask

    task automatic test_full_word();
        for (int i = 0; i < NUM_REGS; i++) begin
            axi_write("full_word", reg_address(i, 0), $urandom, 4'hf, 0, 0, 0);
        end
        for (int i = 0; i < NUM_REGS; i++) begin
            axi_read("full_word", reg_address(i, 0), model[i], 0);
        end
        compare_registers("full_word");
    endtask

    task automatic test_byte_strobes();
        int          index;
        logic [3:0]  strobe;
        logic [31:0] data;
        repeat (24) begin
            index  = $urandom % NUM_REGS;
            strobe = 4'($urandom);
            data   = $urandom;
            axi_write("byte_strobes", reg_address(index, 0), data, strobe, 0, 0, 0);
            axi_read("byte_strobes", reg_address(index, 0), model[index], 0);
        end
        compare_registers("byte_strobes");
    endtask

    task automatic test_address_mapping();
        for (int i = 0; i < NUM_REGS; i++) begin
            axi_write("address_mapping", reg_address(i, 1 + $urandom % 3), $urandom,
                      4'hf, 0, 0, 0);
            axi_read("address_mapping", reg_address(i, $urandom % 4), model[i], 0);
        end
        // One index past the end of the bank
        axi_write("address_mapping", reg_address(NUM_REGS, 0), 32'hffff_ffff, 4'hf, 0, 0, 0);
        compare_registers("address_mapping");
        axi_read("address_mapping", reg_address(NUM_REGS, 0), 32'd0, 0);
    endtask

    // Concurrent write and read of different registers with stalls on B and R
    task automatic test_back_pressure();
        int          write_index;
        int          read_index;
        logic [31:0] data;
        int          aw_delay;
        int          w_delay;
        int          b_hold;
        int          r_hold;
        repeat (20) begin
            write_index = $urandom % NUM_REGS;
            read_index  = (write_index + 1 + $urandom % (NUM_REGS - 1)) % NUM_REGS;
            data        = $urandom;
            aw_delay    = $urandom % 4;
            w_delay     = $urandom % 4;
            b_hold      = $urandom % 8;
            r_hold      = $urandom % 8;
            fork
                axi_write("back_pressure", reg_address(write_index, 0), data, 4'hf,
                          aw_delay, w_delay, b_hold);
                axi_read("back_pressure", reg_address(read_index, 0), model[read_index],
                         r_hold);
            join
        end
        compare_registers("back_pressure");
    endtask

    initial begin
        repeat (TRANSACTIONS * 50) @(posedge clock);
        $display("Result: FAILED");
        $fatal(1, "Watchdog expired before the tests finished");
    end

    initial begin
        reset    = 1'b0;
        aw_valid = 1'b0;
        aw       = '0;
        w_valid  = 1'b0;
        w        = '0;
        b_ready  = 1'b0;
        ar_valid = 1'b0;
        ar       = '0;
        r_ready  = 1'b0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model[i] = 32'd0;
        end
        void'($urandom(32'hdcbe));
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
        test_reset_state();
        test_full_word();
        test_byte_strobes();
        test_address_mapping();
        test_back_pressure();
        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- tb.f
+incdir+common
common/regbus_pkg.sv
axil_slave/axil_skid_buffer.sv
axil_slave/axil_register_cu.sv
rtl/register_bank.sv
rtl/axil_register_subsystem.sv
sim/tb_axil_register_subsystem.sv

//--- Makefile
# Verilator simulation of the AXI4-Lite register slave

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, pass or fail read from $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f tb.f \
		--top-module tb_axil_register_subsystem -o tb_sim
	-./obj_dir/tb_sim > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
